/* build.f */
verilog/env_gen_pkg.sv
verilog/env_rate_counter.sv
verilog/env_phase_ctrl.sv
verilog/env_level_acc.sv
verilog/env_output_scale.sv
verilog/env_gen_top.sv
tb/env_gen_checker.sv
tb/env_gen_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the envelope generator testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=env_gen_tb
OBJ_DIR=obj_dir

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 --top-module "$TOP" -Mdir "$OBJ_DIR" -f build.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

sim_output=$("./$OBJ_DIR/V$TOP" 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Simulation completed successfully"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* tb/env_gen_tb.sv */
// envelope generator testbench driving ADSR sequences against a reference model
`timescale 1ns/1ps

module env_gen_tb import env_gen_pkg::*; ();

    localparam int SUSTAIN_SHIFT = 5;
    localparam int PULSE_SPACING = 16;

    logic         clk;
    logic         arst_n;
    logic         sample_clk_en;
    logic         key_on;
    logic         egt;
    logic         ksr;
    logic         nts;
    fnum_t        fnum;
    block_t       block;
    rate_t        ar;
    rate_t        dr;
    rate_t        rr;
    sustain_t     sl;
    total_level_t tl;
    env_level_t   env_out;

    // reference model state is stepped once per sample tick
    env_phase_t model_phase;
    int         model_level;
    int         model_acc;

    int exp_q[$];
    int seed;
    int error_count;
    int cfg;
    int wait_cycles;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    env_gen_top #(
        .SUSTAIN_SHIFT(SUSTAIN_SHIFT)
    ) UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .sample_clk_en (sample_clk_en),
        .key_on        (key_on),
        .egt           (egt),
        .ksr           (ksr),
        .nts           (nts),
        .fnum          (fnum),
        .block         (block),
        .ar            (ar),
        .dr            (dr),
        .rr            (rr),
        .sl            (sl),
        .tl            (tl),
        .env_out       (env_out)
    );

    // ##################################################
    // reference model
    // ##################################################

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    // phase moves that follow from the level alone between ticks
    function automatic void settle_phase();
        if (model_phase == PHASE_ATTACK && model_level == 0) begin
            model_phase = PHASE_DECAY;
        end
        if (model_phase == PHASE_DECAY && model_level >= (int'(sl) << SUSTAIN_SHIFT)) begin
            model_phase = egt ? PHASE_SUSTAIN : PHASE_RELEASE;
        end
    endfunction

    // one tick of the envelope that returns the expected env_out
    function automatic int model_pulse();
        int req;
        int ks;
        int eff;
        int sum;
        int n;
        case (model_phase)
            PHASE_ATTACK:  req = int'(ar);
            PHASE_DECAY:   req = int'(dr);
            PHASE_SUSTAIN: req = 0;
            default:       req = int'(rr);
        endcase
        // block on top and the split fnum bit at the bottom
        ks = 2 * int'(block) + int'(nts ? fnum[8] : fnum[9]);
        if (!ksr) begin
            ks = ks / 4;
        end
        eff = (ks + 4 * req > 63) ? 63 : ks + 4 * req;
        n = 0;
        if (req != 0) begin
            sum = model_acc + ((4 + eff % 4) << (eff / 4));
            model_acc = sum % 32768;
            n = sum / 32768;
        end
        if (model_phase == PHASE_ATTACK) begin
            model_level = (ar == 4'd15) ? 0 : model_level - n * (model_level / 8 + 1);
            if (model_level < 0) begin
                model_level = 0;
            end
        end else if (model_phase != PHASE_SUSTAIN) begin
            model_level = (model_level + n > 511) ? 511 : model_level + n;
        end
        settle_phase();
        return (model_level + 4 * int'(tl) > 511) ? 511 : model_level + 4 * int'(tl);
    endfunction

    // ##################################################
    // checks and stimulus
    // ##################################################

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            error_count++;
            abort_run($sformatf("** Error at %0t: %s is %0d, expected %0d",
                                $time, what, actual, expected));
        end
    endtask

    // one tick in the middle of a quiet window so settings never sit near it
    task automatic send_pulse();
        repeat (8) @(negedge clk);
        sample_clk_en = 1'b1;
        exp_q.push_back(model_pulse());
        @(negedge clk);
        sample_clk_en = 1'b0;
        repeat (PULSE_SPACING - 9) @(negedge clk);
    endtask

    task automatic run_pulses(input int count);
        repeat (count) send_pulse();
    endtask

    // a negative level means only the phase matters
    task automatic run_until(input env_phase_t target, input int level,
                             input int max_pulses, input string what);
        int count;
        count = 0;
        while (model_phase != target || (level >= 0 && model_level != level)) begin
            if (count == max_pulses) begin
                abort_run($sformatf("timeout after %0d ticks waiting for %s", count, what));
            end else begin
                send_pulse();
                count++;
            end
        end
    endtask

    task automatic set_key(input logic level);
        if (level && !key_on) begin
            model_phase = PHASE_ATTACK;
        end else if (!level && key_on) begin
            model_phase = PHASE_RELEASE;
        end
        key_on = level;
        settle_phase();
    endtask

    task automatic randomize_settings();
        fnum  = fnum_t'(rand_range(0, 1023));
        block = block_t'(rand_range(0, 7));
        ar    = rate_t'(rand_range(11, 14));
        dr    = rate_t'(rand_range(12, 15));
        rr    = rate_t'(rand_range(12, 15));
        sl    = sustain_t'(rand_range(1, 15));
        tl    = total_level_t'(rand_range(0, 63));
    endtask

    // env_out lands three edges after the edge that sees the tick
    initial begin : compare_proc
        forever begin
            @(posedge clk);
            if (sample_clk_en === 1'b1) begin
                repeat (2) @(posedge clk);
                @(negedge clk);
                if (exp_q.size() == 0) begin
                    abort_run("sample tick seen with no expected value queued");
                end else begin
                    check_value(int'(env_out), exp_q.pop_front(), "env_out");
                end
            end
        end
    end

    initial begin : main_seq
        seed          = 76;
        error_count   = 0;
        arst_n        = 1'b0;
        sample_clk_en = 1'b0;
        key_on        = 1'b0;
        egt           = 1'b1;
        ksr           = 1'b0;
        nts           = 1'b0;
        model_phase   = PHASE_RELEASE;
        model_level   = 511;
        model_acc     = 0;
        randomize_settings();
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // with the key up after reset the operator stays silent
        run_pulses(20);

        // full envelope with sustain for each ksr and nts pair
        for (cfg = 0; cfg < 4; cfg++) begin
            randomize_settings();
            // split bits differ so the keyboard split moves the offset
            fnum[9] = ~fnum[8];
            ksr = cfg[0];
            nts = cfg[1];
            egt = 1'b1;
            set_key(1'b1);
            run_until(PHASE_DECAY, -1, 800, "the end of attack");
            run_until(PHASE_SUSTAIN, -1, 2500, "decay to reach sustain");
            run_pulses(12);
            set_key(1'b0);
            run_until(PHASE_RELEASE, 511, 2500, "release to reach silence");
        end

        // instant attack and then decay runs on into release with egt low
        randomize_settings();
        ar  = 4'd15;
        tl  = '0;
        egt = 1'b0;
        set_key(1'b1);
        send_pulse();
        run_until(PHASE_RELEASE, 511, 2500, "decay to run into release");
        set_key(1'b0);

        // key off in the middle of a slow attack
        randomize_settings();
        ar  = 4'd11;
        ksr = 1'b0;
        set_key(1'b1);
        run_pulses(10);
        set_key(1'b0);
        run_until(PHASE_RELEASE, 511, 2500, "release after attack");

        // key off during decay with every rate clamped at 63
        randomize_settings();
        ar    = 4'd14;
        rr    = 4'd15;
        sl    = 4'd15;
        egt   = 1'b1;
        ksr   = 1'b1;
        nts   = 1'b0;
        block = 3'd7;
        fnum  = 10'h3ff;
        set_key(1'b1);
        run_until(PHASE_DECAY, -1, 800, "the end of a fast attack");
        run_pulses(5);
        set_key(1'b0);
        run_until(PHASE_RELEASE, 511, 400, "fast release");

        for (wait_cycles = 0; exp_q.size() != 0; wait_cycles++) begin
            if (wait_cycles == 8) begin
                abort_run("timeout waiting for the last compare");
            end else begin
                @(negedge clk);
            end
        end

        if (error_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("mismatches were found");
        end
    end

endmodule

/* tb/env_gen_checker.sv */
// envelope generator assertion checker for tick, sustain and range rules
`timescale 1ns/1ps

module env_gen_checker import env_gen_pkg::*; (
    input logic       clk,
    input logic       arst_n,
    input logic       sample_clk_en,
    input logic       overflow_valid,
    input env_phase_t phase,
    input env_level_t env_level,
    input env_level_t env_out
);

    // a carry strobe only ever follows a sample tick by one cycle
    valid_after_tick: assert property (@(posedge clk) disable iff (!arst_n)
        overflow_valid |-> $past(sample_clk_en))
        else $error("overflow_valid without a sample tick on the cycle before");

    // the level is frozen for as long as sustain is active
    sustain_holds: assert property (@(posedge clk) disable iff (!arst_n)
        phase == PHASE_SUSTAIN |=> $stable(env_level))
        else $error("env_level moved while the phase was sustain");

    // total level only pushes the output toward silence and saturation never wraps it
    out_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        env_out >= $past(env_level))
        else $error("env_out below the envelope level it was built from");

endmodule

bind env_gen_top env_gen_checker u_env_gen_checker (
    .clk            (clk),
    .arst_n         (arst_n),
    .sample_clk_en  (sample_clk_en),
    .overflow_valid (overflow_valid),
    .phase          (phase),
    .env_level      (env_level),
    .env_out        (env_out)
);

/* verilog/env_gen_top.sv */
// envelope generator top level for one FM operator
`timescale 1ns/1ps

module env_gen_top import env_gen_pkg::*; #(
    parameter int SUSTAIN_SHIFT = 5
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         sample_clk_en,
    input  logic         key_on,
    input  logic         egt,
    input  logic         ksr,
    input  logic         nts,
    input  fnum_t        fnum,
    input  block_t       block,
    input  rate_t        ar,
    input  rate_t        dr,
    input  rate_t        rr,
    input  sustain_t     sl,
    input  total_level_t tl,
    output env_level_t   env_out
);

    env_phase_t phase;
    rate_t      requested_rate;
    logic       attack_instant;
    overflow_t  overflow;
    logic       overflow_valid;
    env_level_t env_level;

    // ##################################################
    // control
    // ##################################################

    env_phase_ctrl #(
        .SUSTAIN_SHIFT(SUSTAIN_SHIFT)
    ) u_env_phase_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .key_on         (key_on),
        .egt            (egt),
        .ar             (ar),
        .dr             (dr),
        .rr             (rr),
        .sl             (sl),
        .env_level      (env_level),
        .phase          (phase),
        .requested_rate (requested_rate),
        .attack_instant (attack_instant)
    );

    // ##################################################
    // datapath, sample tick at +0 gives env_out at +3
    // ##################################################

    env_rate_counter u_env_rate_counter (
        .clk            (clk),
        .arst_n         (arst_n),
        .sample_clk_en  (sample_clk_en),
        .ksr            (ksr),
        .nts            (nts),
        .fnum           (fnum),
        .block          (block),
        .requested_rate (requested_rate),
        .overflow       (overflow),
        .overflow_valid (overflow_valid)
    );

    env_level_acc u_env_level_acc (
        .clk            (clk),
        .arst_n         (arst_n),
        .phase          (phase),
        .overflow       (overflow),
        .overflow_valid (overflow_valid),
        .attack_instant (attack_instant),
        .env_level      (env_level)
    );

    env_output_scale u_env_output_scale (
        .clk       (clk),
        .arst_n    (arst_n),
        .env_level (env_level),
        .tl        (tl),
        .env_out   (env_out)
    );

endmodule

/* verilog/env_output_scale.sv */
// envelope output stage adding the total level offset with saturation
`timescale 1ns/1ps

module env_output_scale import env_gen_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  env_level_t   env_level,
    input  total_level_t tl,
    output env_level_t   env_out
);

    // spare bit catches sums above silence
    localparam int SUM_WIDTH = $bits(env_level_t) + 1;

    logic [SUM_WIDTH-1:0] tl_offset;
    logic [SUM_WIDTH-1:0] level_sum;
    env_level_t           level_sat;

    // ##################################################
    // offset and saturation
    // ##################################################

    // each total level step is worth four envelope steps
    assign tl_offset = SUM_WIDTH'({tl, 2'b00});
    assign level_sum = SUM_WIDTH'(env_level) + tl_offset;

    always_comb begin
        if (level_sum > SUM_WIDTH'(ENV_LEVEL_MAX)) begin
            level_sat = ENV_LEVEL_MAX;
        end else begin
            level_sat = level_sum[$bits(env_level_t)-1:0];
        end
    end

    // ##################################################
    // output register
    // ##################################################

    // starts silent to match the level accumulator
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            env_out <= ENV_LEVEL_MAX;
        end else begin
            env_out <= level_sat;
        end
    end

endmodule

/* verilog/env_level_acc.sv */
// envelope level accumulator applying attack curve and linear rise per carry count
`timescale 1ns/1ps

module env_level_acc import env_gen_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  env_phase_t phase,
    input  overflow_t  overflow,
    input  logic       overflow_valid,
    input  logic       attack_instant,
    output env_level_t env_level
);

    // one extra bit holds the carry out of the rise and the attack step
    localparam int CALC_WIDTH = $bits(env_level_t) + 1;

    logic [CALC_WIDTH-1:0] attack_step;
    logic [CALC_WIDTH-1:0] rise_sum;
    env_level_t            attack_level;
    env_level_t            rise_level;
    env_level_t            next_level;

    // ##################################################
    // attack
    // ##################################################

    // step size scales with the level so the curve is roughly exponential
    // and the largest step is 7 * 64 = 448, well inside the calc width
    assign attack_step = CALC_WIDTH'(overflow)
                       * (CALC_WIDTH'(env_level >> 3) + CALC_WIDTH'(1));

    always_comb begin
        if (attack_instant) begin
            attack_level = '0;
        end else if (attack_step >= CALC_WIDTH'(env_level)) begin
            // floor at full volume
            attack_level = '0;
        end else begin
            attack_level = env_level - attack_step[$bits(env_level_t)-1:0];
        end
    end

    // ##################################################
    // decay and release
    // ##################################################

    assign rise_sum = CALC_WIDTH'(env_level) + CALC_WIDTH'(overflow);

    // clamp at silence
    assign rise_level = (rise_sum > CALC_WIDTH'(ENV_LEVEL_MAX)) ? ENV_LEVEL_MAX
                                                                : rise_sum[8:0];

    always_comb begin
        unique case (phase)
            PHASE_ATTACK:  next_level = attack_level;
            PHASE_DECAY:   next_level = rise_level;
            PHASE_SUSTAIN: next_level = env_level;
            default:       next_level = rise_level;
        endcase
    end

    // the level only moves on a carry strobe from the rate counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            env_level <= ENV_LEVEL_MAX;
        end else if (overflow_valid) begin
            env_level <= next_level;
        end
    end

endmodule

/* verilog/env_phase_ctrl.sv */
// envelope phase state machine with key edge detection and rate selection
`timescale 1ns/1ps

module env_phase_ctrl import env_gen_pkg::*; #(
    parameter int SUSTAIN_SHIFT = 5
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       key_on,
    input  logic       egt,
    input  rate_t      ar,
    input  rate_t      dr,
    input  rate_t      rr,
    input  sustain_t   sl,
    input  env_level_t env_level,
    output env_phase_t phase,
    output rate_t      requested_rate,
    output logic       attack_instant
);

    logic       key_on_q;
    logic       key_rise;
    logic       key_fall;
    env_level_t sustain_level;
    env_phase_t next_phase;

    // ##################################################
    // key edges
    // ##################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key_on_q <= 1'b0;
        end else begin
            key_on_q <= key_on;
        end
    end

    assign key_rise = key_on & ~key_on_q;
    assign key_fall = ~key_on & key_on_q;

    // the sustain setting is coarse, each step spans 2^SUSTAIN_SHIFT levels
    assign sustain_level = env_level_t'(sl) << SUSTAIN_SHIFT;

    // ##################################################
    // phase state machine
    // ##################################################

    always_comb begin
        next_phase = phase;
        if (key_fall) begin
            // releasing the key overrides whatever phase is running
            next_phase = PHASE_RELEASE;
        end else if (key_rise) begin
            next_phase = PHASE_ATTACK;
        end else begin
            unique case (phase)
                PHASE_ATTACK: begin
                    // attack ends once full volume is reached
                    if (env_level == '0) begin
                        next_phase = PHASE_DECAY;
                    end
                end
                PHASE_DECAY: begin
                    // egt low means the sound decays straight on into release
                    if (env_level >= sustain_level) begin
                        next_phase = egt ? PHASE_SUSTAIN : PHASE_RELEASE;
                    end
                end
                PHASE_SUSTAIN: begin
                    next_phase = PHASE_SUSTAIN;
                end
                default: begin
                    next_phase = PHASE_RELEASE;
                end
            endcase
        end
    end

    // after reset the operator sits silent in release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= PHASE_RELEASE;
        end else begin
            phase <= next_phase;
        end
    end

    // ##################################################
    // rate selection
    // ##################################################

    always_comb begin
        unique case (phase)
            PHASE_ATTACK:  requested_rate = ar;
            PHASE_DECAY:   requested_rate = dr;
            PHASE_SUSTAIN: requested_rate = '0;
            default:       requested_rate = rr;
        endcase
    end

    // the level accumulator only honours this while in attack
    assign attack_instant = (ar == RATE_INSTANT);

endmodule

/* verilog/env_rate_counter.sv */
// envelope rate counter turning the requested rate into carry counts per sample
`timescale 1ns/1ps

module env_rate_counter import env_gen_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         sample_clk_en,
    input  logic         ksr,
    input  logic         nts,
    input  fnum_t        fnum,
    input  block_t       block,
    input  rate_t        requested_rate,
    output overflow_t    overflow,
    output logic         overflow_valid
);

    // the sum needs room for the accumulator plus the carry count above it
    localparam int SUM_WIDTH = RATE_ACC_WIDTH + $bits(overflow_t);

    logic                      fnum_bit;
    logic [3:0]                ks_offset;
    logic [3:0]                ks_scaled;
    logic [6:0]                rate_sum;
    eff_rate_t                 eff_rate;
    logic [SUM_WIDTH-1:0]      rate_step;
    logic [SUM_WIDTH-1:0]      acc_sum;
    logic [RATE_ACC_WIDTH-1:0] rate_acc;

    // ##################################################
    // key scale rate
    // ##################################################

    // keyboard split picks fnum bit 9 or bit 8 as the lowest offset bit
    assign fnum_bit  = nts ? fnum[8] : fnum[9];
    assign ks_offset = {block, fnum_bit};

    // without ksr only the top two block bits contribute
    assign ks_scaled = ksr ? ks_offset : (ks_offset >> 2);

    // offset plus four times the rate can reach 75, so one spare bit
    assign rate_sum = 7'(ks_scaled) + 7'({requested_rate, 2'b00});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            eff_rate <= '0;
        end else if (rate_sum > 7'(EFF_RATE_MAX)) begin
            eff_rate <= EFF_RATE_MAX;
        end else begin
            eff_rate <= rate_sum[5:0];
        end
    end

    // ##################################################
    // fractional accumulator
    // ##################################################

    // mantissa 4 to 7 from the low rate bits, shifted by the upper four
    assign rate_step = SUM_WIDTH'({1'b1, eff_rate[1:0]}) << eff_rate[5:2];
    assign acc_sum   = SUM_WIDTH'(rate_acc) + rate_step;

    // carries and the valid strobe both land one cycle after the sample tick
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rate_acc       <= '0;
            overflow       <= '0;
            overflow_valid <= 1'b0;
        end else begin
            overflow_valid <= sample_clk_en;
            if (sample_clk_en) begin
                if (requested_rate != '0) begin
                    rate_acc <= acc_sum[RATE_ACC_WIDTH-1:0];
                    overflow <= acc_sum[SUM_WIDTH-1:RATE_ACC_WIDTH];
                end else begin
                    // a zero rate freezes the accumulator and reports no carry
                    overflow <= '0;
                end
            end
        end
    end

endmodule

/* verilog/env_gen_pkg.sv */
// envelope generator package with shared widths, phase encoding and limits

package env_gen_pkg;

    // ##################################################
    // pitch inputs
    // ##################################################

    // frequency number of the operator, top bits feed key scaling
    typedef logic [9:0] fnum_t;

    // octave block of the operator
    typedef logic [2:0] block_t;

    // ##################################################
    // rate path
    // ##################################################

    // requested rate as set for attack, decay and release
    typedef logic [3:0] rate_t;

    // effective rate after key scaling, 0 to 63
    typedef logic [5:0] eff_rate_t;

    // carry count out of the rate accumulator, 0 to 7
    typedef logic [2:0] overflow_t;

    // width of the fractional rate accumulator
    localparam int RATE_ACC_WIDTH = 15;

    // highest effective rate, larger sums are clamped here
    localparam eff_rate_t EFF_RATE_MAX = 6'd63;

    // an attack rate of this value jumps straight to full volume
    localparam rate_t RATE_INSTANT = 4'd15;

    // ##################################################
    // level path
    // ##################################################

    // attenuation in steps, 0 is loudest and 511 is silent
    typedef logic [8:0] env_level_t;

    // sustain level and total level settings
    typedef logic [3:0] sustain_t;
    typedef logic [5:0] total_level_t;

    // full attenuation
    localparam env_level_t ENV_LEVEL_MAX = 9'd511;

    // envelope phases in the order a held key walks through them
    typedef enum logic [1:0] {
        PHASE_ATTACK,
        PHASE_DECAY,
        PHASE_SUSTAIN,
        PHASE_RELEASE
    } env_phase_t;

endpackage
